// File: files.f
wishbone_pkg.sv
mmc_wb.sv
wb_ram.sv
wb_led.sv
wb_keys.sv
soc_bus_top.sv
tb_soc_bus.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f files.f --top-module tb_soc_bus -o tb_soc_bus &&
./obj_dir/tb_soc_bus | awk '{ print } /^No errors$/ { ok = 1 } END { exit !ok }' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus;

  import wishbone_pkg::*;

  localparam int WAIT_LIMIT = 50;
  localparam int N_WORDS    = 16;

  typedef enum logic [1:0] {RGN_NONE, RGN_MEM, RGN_LED, RGN_KEYS} region_e;

  // expected response of one accepted strobe
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  tga;
    logic [3:0]  tgd;
    logic [3:0]  tgc;
    logic        err;
    logic        chk_data;
  } exp_t;

  logic                 clk;
  logic                 rst;
  bus_req_t             cpu_req;
  bus_rsp_t             cpu_rsp;
  logic [LED_WIDTH-1:0] keys;
  logic [LED_WIDTH-1:0] led;

  exp_t                 exp_q[$];   // in order of acceptance
  logic [31:0]          mem_model [MEM_WORDS];
  bit                   mem_valid [MEM_WORDS];
  logic [LED_WIDTH-1:0] led_model;
  logic [LED_WIDTH-1:0] level_model;
  logic [LED_WIDTH-1:0] press_model;
  logic [31:0]          ram_ofs [N_WORDS];

  int data_errs    = 0;
  int proto_errs   = 0;
  int timeout_errs = 0;
  int ack_count    = 0;
  int last_stalls  = 0;
  bit no_stall_phase = 1'b0;

  soc_bus_top soc_bus_top_inst (
    .clk       (clk),
    .rst       (rst),
    .cpu_req_i (cpu_req),
    .cpu_rsp_o (cpu_rsp),
    .keys_i    (keys),
    .led_o     (led)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // **************************************************
  // reference model of the map
  // **************************************************

  function automatic region_e region_of(input logic [31:0] adr);
    if (adr <= MEM_ADDR_HI)
      return RGN_MEM;
    else if (adr >= LED_ADDR_LO && adr <= LED_ADDR_HI)
      return RGN_LED;
    else if (adr >= KEYS_ADDR_LO && adr <= KEYS_ADDR_HI)
      return RGN_KEYS;
    return RGN_NONE;
  endfunction

  task automatic show_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    data_errs++;
    $display("mismatch %s: got %h expected %h", name, got, exp);
  endtask

  task automatic note_failure(input string msg);
    proto_errs++;
    $display("%s", msg);
  endtask

  task automatic accept_req(input bus_req_t req);
    exp_t        e;
    logic [31:0] ofs;
    logic [12:0] idx;
    e     = '0;
    e.tga = req.Tga;
    e.tgd = req.Tgd;
    e.tgc = req.Tgc;
    case (region_of(req.Adr))
      RGN_MEM:
      begin
        ofs = req.Adr - MEM_ADDR_LO;
        idx = ofs[14:2];
        if (req.We)
        begin
          for (int b = 0; b < 4; b++)
            if (req.Sel[b])
              mem_model[idx][8*b +: 8] = req.Data[8*b +: 8];  // merge written lanes
          if (req.Sel == 4'hF)
            mem_valid[idx] = 1'b1;
        end
        else
        begin
          e.chk_data = mem_valid[idx];
          e.data     = mem_model[idx];
        end
      end
      RGN_LED:
      begin
        if (req.We && req.Sel[0])
          led_model = req.Data[LED_WIDTH-1:0];
        else if (!req.We)
        begin
          e.chk_data = 1'b1;
          e.data     = {{(32-LED_WIDTH){1'b0}}, led_model};
        end
      end
      RGN_KEYS:
      begin
        ofs = req.Adr - KEYS_ADDR_LO;
        if (req.We && req.Sel[0] && ofs == KEYS_PRESS_OFS)
          press_model = press_model & ~req.Data[LED_WIDTH-1:0];
        else if (!req.We)
        begin
          e.chk_data = 1'b1;
          if (ofs == KEYS_PRESS_OFS)
            e.data = {{(32-LED_WIDTH){1'b0}}, press_model};
          else if (ofs == KEYS_LEVEL_OFS)
            e.data = {{(32-LED_WIDTH){1'b0}}, level_model};
        end
      end
      default:
      begin
        // null response carries ack+err with zero data and tags
        e.err      = 1'b1;
        e.tga      = '0;
        e.tgd      = '0;
        e.tgc      = '0;
        e.chk_data = 1'b1;
      end
    endcase
    exp_q.push_back(e);
  endtask

  task automatic check_rsp(input bus_rsp_t rsp);
    exp_t e;
    if (exp_q.size() == 0)
      note_failure("ack arrived with no strobe outstanding");
    else
    begin
      e = exp_q.pop_front();
      ack_count++;
      assert (rsp.Err == e.err) else show_mismatch("Err", 32'(rsp.Err), 32'(e.err));
      assert (rsp.Rty == 1'b0) else show_mismatch("Rty", 32'(rsp.Rty), 32'h0);
      assert (rsp.Tga == e.tga) else show_mismatch("Tga", 32'(rsp.Tga), 32'(e.tga));
      assert (rsp.Tgd == e.tgd) else show_mismatch("Tgd", 32'(rsp.Tgd), 32'(e.tgd));
      assert (rsp.Tgc == e.tgc) else show_mismatch("Tgc", 32'(rsp.Tgc), 32'(e.tgc));
      if (e.chk_data)
        assert (rsp.Data == e.data) else show_mismatch("Data", rsp.Data, e.data);
    end
  endtask

  // **************************************************
  // monitor and protocol checks
  // **************************************************

  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (cpu_rsp.Ack)
        check_rsp(cpu_rsp);
      if (cpu_req.Cyc && cpu_req.Stb && !cpu_rsp.Stall)
        accept_req(cpu_req);  // taken at the coming edge
    end
  end

  assert property (@(negedge clk) disable iff (rst) cpu_rsp.Err |-> cpu_rsp.Ack)
  else
    note_failure("Err raised without Ack");

  assert property (@(negedge clk) disable iff (rst) no_stall_phase |-> !cpu_rsp.Stall)
  else
    note_failure("stall raised during a RAM burst");

  // **************************************************
  // bus master
  // **************************************************

  function automatic bus_req_t make_req(input logic [31:0] adr, input logic [31:0] data,
                                        input logic we, input logic [3:0] sel);
    bus_req_t    req;
    logic [31:0] rnd;
    rnd     = $urandom();
    req     = '0;
    req.Adr  = adr;
    req.Data = data;
    req.We   = we;
    req.Sel  = sel;
    req.Cyc  = 1'b1;
    req.Stb  = 1'b1;
    req.Tga  = rnd[3:0];
    req.Tgd  = rnd[7:4];
    req.Tgc  = rnd[11:8];
    return req;
  endfunction

  // called just after a rising edge, returns at the edge that takes the strobe
  task automatic send(input bus_req_t req);
    int waited;
    cpu_req <= req;
    waited = 0;
    @(negedge clk);
    while (cpu_rsp.Stall && waited < WAIT_LIMIT)
    begin
      waited++;
      @(negedge clk);
    end
    if (cpu_rsp.Stall)
    begin
      timeout_errs++;
      $display("timeout: strobe to %h stayed stalled", req.Adr);
    end
    last_stalls = waited;
    @(posedge clk);
  endtask

  task automatic write_word(input logic [31:0] adr, input logic [31:0] data, input logic [3:0] sel);
    send(make_req(adr, data, 1'b1, sel));
  endtask

  task automatic read_word(input logic [31:0] adr);
    send(make_req(adr, 32'h0, 1'b0, 4'hF));
  endtask

  task automatic drain();
    int waited;
    cpu_req <= '0;
    waited = 0;
    @(posedge clk);
    while (exp_q.size() != 0 && waited < WAIT_LIMIT)
    begin
      waited++;
      @(posedge clk);
    end
    if (exp_q.size() != 0)
    begin
      timeout_errs++;
      $display("timeout: %0d responses never arrived", exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic drive_keys(input logic [LED_WIDTH-1:0] value);
    keys <= value;
    press_model = press_model | (value & ~level_model);
    level_model = value;
    repeat (6) @(posedge clk);  // synchronizer and edge detect settle
  endtask

  task automatic check_led(input logic [LED_WIDTH-1:0] exp_led);
    @(negedge clk);
    assert (led == exp_led) else show_mismatch("led_o", 32'(led), 32'(exp_led));
    @(posedge clk);
  endtask

  // **************************************************
  // stimulus
  // **************************************************

  initial
  begin
    logic [31:0]          rnd;
    logic [31:0]          adr;
    logic [31:0]          wdata;
    int                   acks_before;
    int                   tries;

    rnd = $urandom(32'hada1);
    cpu_req <= '0;
    rst     <= 1'b1;
    keys    <= '0;
    led_model   = '0;
    level_model = '0;
    press_model = '0;

    repeat (9) @(posedge clk);
    @(negedge clk);
    assert (!cpu_rsp.Ack && !cpu_rsp.Err && !cpu_rsp.Stall)
    else
      note_failure("response outputs not low in reset");
    assert (led == '0) else show_mismatch("led_o", 32'(led), 32'h0);
    @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    // ram fill, partial lane overwrites, then single read-back
    for (int i = 0; i < N_WORDS; i++)
    begin
      rnd = $urandom();
      ram_ofs[i] = {17'b0, rnd[14:2], 2'b00};
      write_word(MEM_ADDR_LO + ram_ofs[i], $urandom(), 4'hF);
    end
    for (int i = 0; i < N_WORDS; i += 2)
    begin
      rnd = $urandom();
      write_word(MEM_ADDR_LO + ram_ofs[i], $urandom(), rnd[3:0]);
    end
    drain();
    for (int i = 0; i < N_WORDS; i++)
    begin
      read_word(MEM_ADDR_LO + ram_ofs[i]);
      drain();
    end

    // back-to-back reads
    no_stall_phase = 1'b1;
    acks_before = ack_count;
    for (int i = N_WORDS - 1; i >= 0; i--)
      read_word(MEM_ADDR_LO + ram_ofs[i]);
    drain();
    no_stall_phase = 1'b0;
    assert (ack_count - acks_before == N_WORDS)
    else
      note_failure("RAM burst did not get one ack per read");

    // led register
    wdata = $urandom();
    write_word(LED_ADDR_LO, wdata, 4'h1);
    drain();
    check_led(wdata[LED_WIDTH-1:0]);
    write_word(LED_ADDR_LO, ~wdata, 4'hE);  // lane 0 off
    drain();
    check_led(wdata[LED_WIDTH-1:0]);
    read_word(LED_ADDR_LO);
    drain();

    // unmapped strobes, then ram right behind them
    rnd = $urandom();
    read_word({4'h8, rnd[27:2], 2'b00});
    adr = $urandom();
    tries = 0;
    while (region_of(adr) != RGN_NONE && tries < 100)
    begin
      adr = $urandom();
      tries++;
    end
    write_word(adr, $urandom(), 4'hF);
    write_word(MEM_ADDR_LO + ram_ofs[1], $urandom(), 4'hF);
    read_word(MEM_ADDR_LO + ram_ofs[1]);
    drain();

    // key level and press reads back to back so the second is stalled
    rnd = $urandom();
    drive_keys(rnd[LED_WIDTH-1:0]);
    read_word(KEYS_ADDR_LO + KEYS_LEVEL_OFS);
    read_word(KEYS_ADDR_LO + KEYS_PRESS_OFS);
    drain();
    assert (last_stalls > 0)
    else
      note_failure("second key read was accepted without a stall");
    rnd = $urandom();
    drive_keys(rnd[LED_WIDTH-1:0]);
    read_word(KEYS_ADDR_LO + KEYS_LEVEL_OFS);
    read_word(KEYS_ADDR_LO + KEYS_PRESS_OFS);
    write_word(KEYS_ADDR_LO + KEYS_PRESS_OFS, $urandom(), 4'h1);  // clear some
    read_word(KEYS_ADDR_LO + KEYS_PRESS_OFS);
    write_word(KEYS_ADDR_LO + KEYS_PRESS_OFS, 32'hFFFF_FFFF, 4'h1);
    read_word(KEYS_ADDR_LO + KEYS_PRESS_OFS);
    drain();

    repeat (2) @(posedge clk);
    $display("errors: data %0d, protocol %0d, timeout %0d", data_errs, proto_errs, timeout_errs);
    if (data_errs + proto_errs + timeout_errs == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
  input  logic                                 clk,
  input  logic                                 rst,
  input  wishbone_pkg::bus_req_t               cpu_req_i,
  output wishbone_pkg::bus_rsp_t               cpu_rsp_o,
  input  logic [wishbone_pkg::LED_WIDTH-1:0]   keys_i,
  output logic [wishbone_pkg::LED_WIDTH-1:0]   led_o
);

  import wishbone_pkg::*;

  bus_req_t mem_req;
  bus_rsp_t mem_rsp;
  bus_req_t led_req;
  bus_rsp_t led_rsp;
  bus_req_t keys_req;
  bus_rsp_t keys_rsp;

  // **************************************************
  // decoder
  // **************************************************

  mmc_wb mmc_wb_inst (
    .clk         (clk),
    .rst         (rst),
    .riscv_mmc_i (cpu_req_i),
    .mmc_riscv_o (cpu_rsp_o),
    .mmc_mem_o   (mem_req),
    .mem_mmc_i   (mem_rsp),
    .mmc_led_o   (led_req),
    .led_mmc_i   (led_rsp),
    .mmc_keys_o  (keys_req),
    .keys_mmc_i  (keys_rsp)
  );

  // **************************************************
  // slaves
  // **************************************************

  wb_ram wb_ram_inst (
    .clk   (clk),
    .rst   (rst),
    .bus_i (mem_req),
    .bus_o (mem_rsp)
  );

  wb_led wb_led_inst (
    .clk   (clk),
    .rst   (rst),
    .bus_i (led_req),
    .bus_o (led_rsp),
    .led_o (led_o)
  );

  wb_keys wb_keys_inst (
    .clk    (clk),
    .rst    (rst),
    .bus_i  (keys_req),
    .bus_o  (keys_rsp),
    .keys_i (keys_i)  // async pins, synced inside
  );

endmodule

// File: wb_keys.sv
`timescale 1ns/1ps

module wb_keys (
  input  logic                                 clk,
  input  logic                                 rst,
  input  wishbone_pkg::bus_req_t               bus_i,
  output wishbone_pkg::bus_rsp_t               bus_o,
  input  logic [wishbone_pkg::LED_WIDTH-1:0]   keys_i
);

  import wishbone_pkg::*;

  logic [LED_WIDTH-1:0] key_meta;
  logic [LED_WIDTH-1:0] key_level;
  logic [LED_WIDTH-1:0] key_prev;
  logic [LED_WIDTH-1:0] press_q;
  logic [LED_WIDTH-1:0] key_rise;
  logic [LED_WIDTH-1:0] press_clr;
  logic                 req_ok;
  logic                 ack_q;
  logic [31:0]          rdata_q;
  logic [3:0]           tga_q;
  logic [3:0]           tgd_q;
  logic [3:0]           tgc_q;

  // busy while the ack is pending, so one access every other cycle
  assign req_ok    = bus_i.Cyc & bus_i.Stb & ~ack_q;
  assign key_rise  = key_level & ~key_prev;
  assign press_clr = (req_ok & bus_i.We & bus_i.Sel[0] & (bus_i.Adr == KEYS_PRESS_OFS))
                   ? bus_i.Data[LED_WIDTH-1:0] : '0;  // write ones to clear

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      key_meta  <= '0;
      key_level <= '0;
      key_prev  <= '0;
      press_q   <= '0;
      ack_q     <= 1'b0;
    end
    else
    begin
      key_meta  <= keys_i;     // two-flop sync
      key_level <= key_meta;
      key_prev  <= key_level;
      press_q   <= (press_q & ~press_clr) | key_rise;  // new press beats clear
      ack_q     <= req_ok;
    end
  end

  always_ff @(posedge clk)
  begin
    if (req_ok)
    begin
      if (bus_i.Adr == KEYS_PRESS_OFS)
        rdata_q <= {{(32-LED_WIDTH){1'b0}}, press_q};
      else if (bus_i.Adr == KEYS_LEVEL_OFS)
        rdata_q <= {{(32-LED_WIDTH){1'b0}}, key_level};
      else
        rdata_q <= '0;
      tga_q <= bus_i.Tga;
      tgd_q <= bus_i.Tgd;
      tgc_q <= bus_i.Tgc;
    end
  end

  always_comb
  begin
    bus_o       = '0;
    bus_o.Ack   = ack_q;
    bus_o.Stall = ack_q;
    bus_o.Data  = rdata_q;
    bus_o.Tga   = tga_q;
    bus_o.Tgd   = tgd_q;
    bus_o.Tgc   = tgc_q;
  end

endmodule

// File: wb_led.sv
`timescale 1ns/1ps

module wb_led (
  input  logic                                 clk,
  input  logic                                 rst,
  input  wishbone_pkg::bus_req_t               bus_i,
  output wishbone_pkg::bus_rsp_t               bus_o,
  output logic [wishbone_pkg::LED_WIDTH-1:0]   led_o
);

  import wishbone_pkg::*;

  logic                 req_ok;
  logic                 ack_q;
  logic [LED_WIDTH-1:0] led_q;
  logic [31:0]          rdata_q;
  logic [3:0]           tga_q;
  logic [3:0]           tgd_q;
  logic [3:0]           tgc_q;

  assign req_ok = bus_i.Cyc & bus_i.Stb;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ack_q <= 1'b0;
      led_q <= '0;
    end
    else
    begin
      ack_q <= req_ok;
      if (req_ok & bus_i.We & bus_i.Sel[0])
        led_q <= bus_i.Data[LED_WIDTH-1:0];  // lane 0 only
    end
  end

  // readback zero-extended, registered with the ack
  always_ff @(posedge clk)
  begin
    if (req_ok)
    begin
      rdata_q <= {{(32-LED_WIDTH){1'b0}}, led_q};
      tga_q   <= bus_i.Tga;
      tgd_q   <= bus_i.Tgd;
      tgc_q   <= bus_i.Tgc;
    end
  end

  always_comb
  begin
    bus_o      = '0;
    bus_o.Ack  = ack_q;
    bus_o.Data = rdata_q;
    bus_o.Tga  = tga_q;
    bus_o.Tgd  = tgd_q;
    bus_o.Tgc  = tgc_q;
  end

  assign led_o = led_q;

endmodule

// File: wb_ram.sv
`timescale 1ns/1ps

module wb_ram (
  input  logic                   clk,
  input  logic                   rst,
  input  wishbone_pkg::bus_req_t bus_i,
  output wishbone_pkg::bus_rsp_t bus_o
);

  import wishbone_pkg::*;

  logic [31:0]                  mem [MEM_WORDS];
  logic [$clog2(MEM_WORDS)-1:0] word_idx;
  logic                         req_ok;
  logic                         ack_q;
  logic [31:0]                  rdata_q;
  logic [3:0]                   tga_q;
  logic [3:0]                   tgd_q;
  logic [3:0]                   tgc_q;

  assign word_idx = bus_i.Adr[$clog2(MEM_WORDS)+1:2];  // byte offset to word
  assign req_ok   = bus_i.Cyc & bus_i.Stb;               // never stalls

  always_ff @(posedge clk)
  begin
    if (req_ok)
    begin
      if (bus_i.We)
      begin
        for (int b = 0; b < 4; b++)
        begin
          if (bus_i.Sel[b])
            mem[word_idx][8*b +: 8] <= bus_i.Data[8*b +: 8];
        end
      end
      rdata_q <= mem[word_idx];  // old word on a write
      tga_q   <= bus_i.Tga;
      tgd_q   <= bus_i.Tgd;
      tgc_q   <= bus_i.Tgc;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      ack_q <= 1'b0;
    else
      ack_q <= req_ok;
  end

  always_comb
  begin
    bus_o       = '0;
    bus_o.Ack   = ack_q;
    bus_o.Data  = rdata_q;
    bus_o.Tga   = tga_q;
    bus_o.Tgd   = tgd_q;
    bus_o.Tgc   = tgc_q;
  end

endmodule

// File: mmc_wb.sv
`timescale 1ns/1ps

module mmc_wb (
  input  logic                   clk,
  input  logic                   rst,

  input  wishbone_pkg::bus_req_t riscv_mmc_i,
  output wishbone_pkg::bus_rsp_t mmc_riscv_o,

  output wishbone_pkg::bus_req_t mmc_mem_o,
  input  wishbone_pkg::bus_rsp_t mem_mmc_i,

  output wishbone_pkg::bus_req_t mmc_led_o,
  input  wishbone_pkg::bus_rsp_t led_mmc_i,

  output wishbone_pkg::bus_req_t mmc_keys_o,
  input  wishbone_pkg::bus_rsp_t keys_mmc_i
);

  import wishbone_pkg::*;

  logic                 mem_hit;
  logic                 led_hit;
  logic                 keys_hit;
  logic                 bus_stall;
  logic                 null_ack;

  logic [STB_CNT_W-1:0] mem_stb_cnt;
  logic [STB_CNT_W-1:0] led_stb_cnt;
  logic [STB_CNT_W-1:0] keys_stb_cnt;

  // **************************************************
  // master to slaves
  // **************************************************

  assign mem_hit  = (riscv_mmc_i.Adr >= MEM_ADDR_LO) && (riscv_mmc_i.Adr <= MEM_ADDR_HI);
  assign led_hit  = (riscv_mmc_i.Adr >= LED_ADDR_LO) && (riscv_mmc_i.Adr <= LED_ADDR_HI);
  assign keys_hit = (riscv_mmc_i.Adr >= KEYS_ADDR_LO) && (riscv_mmc_i.Adr <= KEYS_ADDR_HI);

  // all fields fan out, only the matching slave sees Stb
  always_comb
  begin
    mmc_mem_o      = riscv_mmc_i;
    mmc_mem_o.Adr  = riscv_mmc_i.Adr - MEM_ADDR_LO;
    mmc_mem_o.Stb  = riscv_mmc_i.Stb & mem_hit;

    mmc_led_o      = riscv_mmc_i;
    mmc_led_o.Adr  = riscv_mmc_i.Adr - LED_ADDR_LO;
    mmc_led_o.Stb  = riscv_mmc_i.Stb & led_hit;

    mmc_keys_o     = riscv_mmc_i;
    mmc_keys_o.Adr = riscv_mmc_i.Adr - KEYS_ADDR_LO;
    mmc_keys_o.Stb = riscv_mmc_i.Stb & keys_hit;
  end

  // **************************************************
  // outstanding strobe counters
  // **************************************************

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mem_stb_cnt  <= '0;
      led_stb_cnt  <= '0;
      keys_stb_cnt <= '0;
    end
    else
    begin
      // raw strobes in, acks out
      mem_stb_cnt  <= mem_stb_cnt + STB_CNT_W'(mmc_mem_o.Stb)
                      - STB_CNT_W'(mem_mmc_i.Ack);
      led_stb_cnt  <= led_stb_cnt + STB_CNT_W'(mmc_led_o.Stb)
                      - STB_CNT_W'(led_mmc_i.Ack);
      keys_stb_cnt <= keys_stb_cnt + STB_CNT_W'(mmc_keys_o.Stb)
                      - STB_CNT_W'(keys_mmc_i.Ack);
    end
  end

  // only a slave with work in flight may hold the master
  assign bus_stall = ((mem_stb_cnt != '0) & mem_mmc_i.Stall)
                   | ((led_stb_cnt != '0) & led_mmc_i.Stall)
                   | ((keys_stb_cnt != '0) & keys_mmc_i.Stall);

  // **************************************************
  // slaves to master
  // **************************************************

  always_comb
  begin
    mmc_riscv_o = '0;

    if (mem_mmc_i.Ack | mem_mmc_i.Err | mem_mmc_i.Rty)
    begin
      mmc_riscv_o = mem_mmc_i;
    end

    if (led_mmc_i.Ack | led_mmc_i.Err | led_mmc_i.Rty)
    begin
      mmc_riscv_o = led_mmc_i;
    end

    if (keys_mmc_i.Ack | keys_mmc_i.Err | keys_mmc_i.Rty)
    begin
      mmc_riscv_o = keys_mmc_i;
    end

    if (null_ack)
    begin
      mmc_riscv_o     = '0;  // zero data and tags
      mmc_riscv_o.Ack = 1'b1;
      mmc_riscv_o.Err = 1'b1;
    end

    mmc_riscv_o.Stall = bus_stall;
  end

  // unmapped strobe gets ack+err next cycle so the master never hangs
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      null_ack <= 1'b0;
    end
    else
    begin
      null_ack <= riscv_mmc_i.Cyc & riscv_mmc_i.Stb & ~bus_stall
                  & ~(mem_hit | led_hit | keys_hit);
    end
  end

endmodule

// File: wishbone_pkg.sv
package wishbone_pkg;

  // **************************************************
  // bus structs
  // **************************************************

  // master to slave request held steady while stalled
  typedef struct packed {
    logic [31:0] Adr;
    logic [31:0] Data;
    logic        We;
    logic [3:0]  Sel;   // byte enables
    logic        Cyc;
    logic        Stb;
    logic [3:0]  Tga;
    logic [3:0]  Tgd;
    logic [3:0]  Tgc;
  } bus_req_t;

  // slave to master
  typedef struct packed {
    logic        Ack;
    logic        Stall;
    logic        Err;
    logic        Rty;
    logic [31:0] Data;
    logic [3:0]  Tga;   // echoed from the request
    logic [3:0]  Tgd;
    logic [3:0]  Tgc;
  } bus_rsp_t;

  // **************************************************
  // address map
  // **************************************************

  localparam logic [31:0] MEM_ADDR_LO  = 32'h0000_0000;
  localparam logic [31:0] MEM_ADDR_HI  = 32'h0000_7FFF;
  localparam logic [31:0] LED_ADDR_LO  = 32'hC000_0000;
  localparam logic [31:0] LED_ADDR_HI  = 32'hC000_FFFF;
  localparam logic [31:0] KEYS_ADDR_LO = 32'hC100_0000;
  localparam logic [31:0] KEYS_ADDR_HI = 32'hC100_FFFF;

  // 32 KiB of 32-bit words
  localparam int MEM_WORDS = 8192;

  // leds out and keys in share one width
  localparam int LED_WIDTH = 8;

  // keys block registers, byte offsets
  localparam logic [31:0] KEYS_LEVEL_OFS = 32'h0000_0000;
  localparam logic [31:0] KEYS_PRESS_OFS = 32'h0000_0004;

  // outstanding strobes per slave
  localparam int STB_CNT_W = 16;

endpackage
